//--- design/isa_pkg.sv
package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] alu_op_t;

    // one-hot alu op bit positions
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    typedef enum logic [3:0] {
        BR_NONE,
        BR_B,
        BR_BL,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU,
        BR_JIRL
    } br_kind_e;

    // bits 31:26
    localparam logic [5:0] OP6_ALU       = 6'h00;
    localparam logic [5:0] OP6_LU12I     = 6'h05;
    localparam logic [5:0] OP6_PCADDU12I = 6'h07;
    localparam logic [5:0] OP6_MEM       = 6'h0a;
    localparam logic [5:0] OP6_JIRL      = 6'h13;
    localparam logic [5:0] OP6_B         = 6'h14;
    localparam logic [5:0] OP6_BL        = 6'h15;
    localparam logic [5:0] OP6_BEQ       = 6'h16;
    localparam logic [5:0] OP6_BNE       = 6'h17;
    localparam logic [5:0] OP6_BLT       = 6'h18;
    localparam logic [5:0] OP6_BGE       = 6'h19;
    localparam logic [5:0] OP6_BLTU      = 6'h1a;
    localparam logic [5:0] OP6_BGEU      = 6'h1b;

    // bits 25:22
    localparam logic [3:0] OP4_3R    = 4'h0;
    localparam logic [3:0] OP4_SHIFT = 4'h1;
    localparam logic [3:0] OP4_LD_W  = 4'h2;
    localparam logic [3:0] OP4_ST_W  = 4'h6;
    localparam logic [3:0] OP4_SLTI  = 4'h8;
    localparam logic [3:0] OP4_SLTUI = 4'h9;
    localparam logic [3:0] OP4_ADDI  = 4'ha;
    localparam logic [3:0] OP4_ANDI  = 4'hd;
    localparam logic [3:0] OP4_ORI   = 4'he;
    localparam logic [3:0] OP4_XORI  = 4'hf;

    // bits 21:20
    localparam logic [1:0] OP2_SHIFT = 2'h0;
    localparam logic [1:0] OP2_3R    = 2'h1;

    // bits 19:15
    localparam logic [4:0] OP5_ADD  = 5'h00;
    localparam logic [4:0] OP5_SLLI = 5'h01;
    localparam logic [4:0] OP5_SUB  = 5'h02;
    localparam logic [4:0] OP5_SLT  = 5'h04;
    localparam logic [4:0] OP5_SLTU = 5'h05;
    localparam logic [4:0] OP5_NOR  = 5'h08;
    localparam logic [4:0] OP5_AND  = 5'h09;
    localparam logic [4:0] OP5_SRLI = 5'h09;
    localparam logic [4:0] OP5_OR   = 5'h0a;
    localparam logic [4:0] OP5_XOR  = 5'h0b;
    localparam logic [4:0] OP5_SLL  = 5'h0e;
    localparam logic [4:0] OP5_SRL  = 5'h0f;
    localparam logic [4:0] OP5_SRA  = 5'h10;
    localparam logic [4:0] OP5_SRAI = 5'h11;

    // link register for bl
    localparam reg_addr_t RA_REG = 5'd1;

endpackage

//--- design/pipe_pkg.sv
package pipe_pkg;

    typedef struct packed {
        isa_pkg::inst_t inst;
        isa_pkg::word_t pc;
    } fs_to_ds_t;

    typedef struct packed {
        isa_pkg::alu_op_t   alu_op;
        isa_pkg::word_t     alu_src1;
        isa_pkg::word_t     alu_src2;
        logic               res_from_mem;
        logic               mem_we;
        logic               rf_we;
        isa_pkg::reg_addr_t rf_waddr;
        isa_pkg::word_t     rkd_value;
        isa_pkg::word_t     pc;
    } ds_to_es_t;

    // result of a later stage, as seen by decode
    typedef struct packed {
        logic               res_from_mem;
        logic               rf_we;
        isa_pkg::reg_addr_t rf_waddr;
        isa_pkg::word_t     wdata;
    } fwd_t;

    typedef struct packed {
        logic               we;
        isa_pkg::reg_addr_t waddr;
        isa_pkg::word_t     wdata;
    } rf_write_t;

    typedef struct packed {
        logic           stall;
        logic           taken;
        isa_pkg::word_t target;
    } br_req_t;

    typedef struct packed {
        isa_pkg::alu_op_t   alu_op;
        isa_pkg::br_kind_e  br_kind;
        logic               src1_is_pc;
        logic               src2_is_imm;
        logic               need_r1;
        logic               need_r2;
        isa_pkg::reg_addr_t raddr1;
        isa_pkg::reg_addr_t raddr2;
        logic               rf_we;
        isa_pkg::reg_addr_t dest;
        logic               res_from_mem;
        logic               mem_we;
        isa_pkg::word_t     imm;
        isa_pkg::word_t     br_offs;
    } dec_ctrl_t;

endpackage

//--- design/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  isa_pkg::inst_t      inst,
    output pipe_pkg::dec_ctrl_t ctrl
);

    logic [5:0]         op6;
    logic [3:0]         op4;
    logic [1:0]         op2;
    logic [4:0]         op5;
    isa_pkg::reg_addr_t rd;
    isa_pkg::reg_addr_t rj;
    isa_pkg::reg_addr_t rk;
    logic [11:0]        i12;
    logic [15:0]        i16;
    logic [19:0]        i20;
    logic [25:0]        i26;
    logic               grp_3r;
    logic               grp_shift;
    logic               grp_imm;
    logic               inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic               inst_nor, inst_and, inst_or, inst_xor;
    logic               inst_sll_w, inst_srl_w, inst_sra_w;
    logic               inst_slli_w, inst_srli_w, inst_srai_w;
    logic               inst_addi_w, inst_slti, inst_sltui;
    logic               inst_andi, inst_ori, inst_xori;
    logic               inst_lu12i_w, inst_pcaddu12i, inst_ld_w, inst_st_w;
    logic               rr_op;
    logic               cond_br;
    logic               known;
    logic               need_ui5, need_si12, need_ui12, need_si20, src2_is_4;
    isa_pkg::br_kind_e  br_kind;

    assign op6 = inst[31:26];
    assign op4 = inst[25:22];
    assign op2 = inst[21:20];
    assign op5 = inst[19:15];
    assign rd  = inst[4:0];
    assign rj  = inst[9:5];
    assign rk  = inst[14:10];
    assign i12 = inst[21:10];
    assign i16 = inst[25:10];
    assign i20 = inst[24:5];
    assign i26 = {inst[9:0], inst[25:10]};

    assign grp_imm   = op6 == isa_pkg::OP6_ALU;
    assign grp_3r    = grp_imm && op4 == isa_pkg::OP4_3R && op2 == isa_pkg::OP2_3R;
    assign grp_shift = grp_imm && op4 == isa_pkg::OP4_SHIFT && op2 == isa_pkg::OP2_SHIFT;

    assign inst_add_w  = grp_3r && op5 == isa_pkg::OP5_ADD;
    assign inst_sub_w  = grp_3r && op5 == isa_pkg::OP5_SUB;
    assign inst_slt    = grp_3r && op5 == isa_pkg::OP5_SLT;
    assign inst_sltu   = grp_3r && op5 == isa_pkg::OP5_SLTU;
    assign inst_nor    = grp_3r && op5 == isa_pkg::OP5_NOR;
    assign inst_and    = grp_3r && op5 == isa_pkg::OP5_AND;
    assign inst_or     = grp_3r && op5 == isa_pkg::OP5_OR;
    assign inst_xor    = grp_3r && op5 == isa_pkg::OP5_XOR;
    assign inst_sll_w  = grp_3r && op5 == isa_pkg::OP5_SLL;
    assign inst_srl_w  = grp_3r && op5 == isa_pkg::OP5_SRL;
    assign inst_sra_w  = grp_3r && op5 == isa_pkg::OP5_SRA;
    assign inst_slli_w = grp_shift && op5 == isa_pkg::OP5_SLLI;
    assign inst_srli_w = grp_shift && op5 == isa_pkg::OP5_SRLI;
    assign inst_srai_w = grp_shift && op5 == isa_pkg::OP5_SRAI;

    // 12-bit immediate forms take op2/op5 as immediate bits
    assign inst_addi_w    = grp_imm && op4 == isa_pkg::OP4_ADDI;
    assign inst_slti      = grp_imm && op4 == isa_pkg::OP4_SLTI;
    assign inst_sltui     = grp_imm && op4 == isa_pkg::OP4_SLTUI;
    assign inst_andi      = grp_imm && op4 == isa_pkg::OP4_ANDI;
    assign inst_ori       = grp_imm && op4 == isa_pkg::OP4_ORI;
    assign inst_xori      = grp_imm && op4 == isa_pkg::OP4_XORI;
    assign inst_lu12i_w   = op6 == isa_pkg::OP6_LU12I && !inst[25];
    assign inst_pcaddu12i = op6 == isa_pkg::OP6_PCADDU12I && !inst[25];
    assign inst_ld_w      = op6 == isa_pkg::OP6_MEM && op4 == isa_pkg::OP4_LD_W;
    assign inst_st_w      = op6 == isa_pkg::OP6_MEM && op4 == isa_pkg::OP4_ST_W;

    // branches are fully identified by the major opcode
    always_comb begin
        case (op6)
            isa_pkg::OP6_JIRL: br_kind = isa_pkg::BR_JIRL;
            isa_pkg::OP6_B:    br_kind = isa_pkg::BR_B;
            isa_pkg::OP6_BL:   br_kind = isa_pkg::BR_BL;
            isa_pkg::OP6_BEQ:  br_kind = isa_pkg::BR_BEQ;
            isa_pkg::OP6_BNE:  br_kind = isa_pkg::BR_BNE;
            isa_pkg::OP6_BLT:  br_kind = isa_pkg::BR_BLT;
            isa_pkg::OP6_BGE:  br_kind = isa_pkg::BR_BGE;
            isa_pkg::OP6_BLTU: br_kind = isa_pkg::BR_BLTU;
            isa_pkg::OP6_BGEU: br_kind = isa_pkg::BR_BGEU;
            default:           br_kind = isa_pkg::BR_NONE;
        endcase
    end

    assign rr_op = inst_add_w | inst_sub_w | inst_slt | inst_sltu | inst_nor | inst_and
                 | inst_or | inst_xor | inst_sll_w | inst_srl_w | inst_sra_w;
    assign cond_br = br_kind inside {isa_pkg::BR_BEQ, isa_pkg::BR_BNE, isa_pkg::BR_BLT,
                                     isa_pkg::BR_BGE, isa_pkg::BR_BLTU, isa_pkg::BR_BGEU};

    assign need_ui5  = inst_slli_w | inst_srli_w | inst_srai_w;
    assign need_si12 = inst_addi_w | inst_slti | inst_sltui | inst_ld_w | inst_st_w;
    assign need_ui12 = inst_andi | inst_ori | inst_xori;
    assign need_si20 = inst_lu12i_w | inst_pcaddu12i;
    assign src2_is_4 = br_kind == isa_pkg::BR_BL || br_kind == isa_pkg::BR_JIRL;
    assign known     = rr_op | need_ui5 | need_si12 | need_ui12 | need_si20
                     | (br_kind != isa_pkg::BR_NONE);

    always_comb begin
        ctrl.alu_op[isa_pkg::ALU_ADD]  = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w
                                       | inst_pcaddu12i | src2_is_4;
        ctrl.alu_op[isa_pkg::ALU_SUB]  = inst_sub_w;
        ctrl.alu_op[isa_pkg::ALU_SLT]  = inst_slt | inst_slti;
        ctrl.alu_op[isa_pkg::ALU_SLTU] = inst_sltu | inst_sltui;
        ctrl.alu_op[isa_pkg::ALU_AND]  = inst_and | inst_andi;
        ctrl.alu_op[isa_pkg::ALU_NOR]  = inst_nor;
        ctrl.alu_op[isa_pkg::ALU_OR]   = inst_or | inst_ori;
        ctrl.alu_op[isa_pkg::ALU_XOR]  = inst_xor | inst_xori;
        ctrl.alu_op[isa_pkg::ALU_SLL]  = inst_sll_w | inst_slli_w;
        ctrl.alu_op[isa_pkg::ALU_SRL]  = inst_srl_w | inst_srli_w;
        ctrl.alu_op[isa_pkg::ALU_SRA]  = inst_sra_w | inst_srai_w;
        ctrl.alu_op[isa_pkg::ALU_LUI]  = inst_lu12i_w;
        ctrl.br_kind      = br_kind;
        // bl and jirl put pc + 4 through the alu as the link value
        ctrl.src1_is_pc   = inst_pcaddu12i | src2_is_4;
        ctrl.src2_is_imm  = need_ui5 | need_si12 | need_ui12 | need_si20 | src2_is_4;
        ctrl.need_r1      = known && !need_si20 && br_kind != isa_pkg::BR_B
                                  && br_kind != isa_pkg::BR_BL;
        ctrl.need_r2      = rr_op | inst_st_w | cond_br;
        ctrl.raddr1       = rj;
        ctrl.raddr2       = (inst_st_w || cond_br) ? rd : rk;
        ctrl.rf_we        = known && !inst_st_w && !cond_br && br_kind != isa_pkg::BR_B;
        ctrl.dest         = (br_kind == isa_pkg::BR_BL) ? isa_pkg::RA_REG : rd;
        ctrl.res_from_mem = inst_ld_w;
        ctrl.mem_we       = inst_st_w;
        if (src2_is_4) begin
            ctrl.imm = 32'd4;
        end else if (need_si20) begin
            ctrl.imm = {i20, 12'b0};
        end else if (need_ui12) begin
            ctrl.imm = {20'b0, i12};
        end else if (need_ui5) begin
            ctrl.imm = {27'b0, rk};
        end else begin
            ctrl.imm = {{20{i12[11]}}, i12};
        end
        if (br_kind == isa_pkg::BR_B || br_kind == isa_pkg::BR_BL) begin
            ctrl.br_offs = {{4{i26[25]}}, i26, 2'b0};
        end else begin
            ctrl.br_offs = {{14{i16[15]}}, i16, 2'b0};
        end
    end

endmodule

//--- design/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                clk,
    input  isa_pkg::reg_addr_t  raddr1,
    input  isa_pkg::reg_addr_t  raddr2,
    input  pipe_pkg::rf_write_t write,
    output isa_pkg::word_t      rdata1,
    output isa_pkg::word_t      rdata2
);

    isa_pkg::word_t rf [32];

    always_ff @(posedge clk) begin
        if (write.we && write.waddr != '0) begin
            rf[write.waddr] <= write.wdata;
        end
    end

    // r0 is hardwired to zero
    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

endmodule

//--- design/operand_bypass.sv
`timescale 1ns/1ps

module operand_bypass (
    input  isa_pkg::reg_addr_t  raddr1,
    input  isa_pkg::reg_addr_t  raddr2,
    input  logic                need_r1,
    input  logic                need_r2,
    input  isa_pkg::word_t      rf_rdata1,
    input  isa_pkg::word_t      rf_rdata2,
    input  pipe_pkg::fwd_t      es_fwd,
    input  pipe_pkg::fwd_t      ms_fwd,
    input  pipe_pkg::rf_write_t ws_write,
    output isa_pkg::word_t      rj_value,
    output isa_pkg::word_t      rkd_value,
    output logic                stall
);

    // youngest writer wins, r0 never forwards
    function automatic isa_pkg::word_t pick(input isa_pkg::reg_addr_t addr,
                                            input isa_pkg::word_t     rf_data);
        isa_pkg::word_t val;
        val = rf_data;
        if (addr != '0) begin
            if (es_fwd.rf_we && es_fwd.rf_waddr == addr) begin
                val = es_fwd.wdata;
            end else if (ms_fwd.rf_we && ms_fwd.rf_waddr == addr) begin
                val = ms_fwd.wdata;
            end else if (ws_write.we && ws_write.waddr == addr) begin
                val = ws_write.wdata;
            end
        end
        return val;
    endfunction

    // load result not ready yet for a source we need
    function automatic logic load_hit(input pipe_pkg::fwd_t f);
        logic hit1;
        logic hit2;
        hit1 = need_r1 && f.rf_waddr == raddr1;
        hit2 = need_r2 && f.rf_waddr == raddr2;
        return f.res_from_mem && f.rf_we && f.rf_waddr != '0 && (hit1 || hit2);
    endfunction

    always_comb begin
        rj_value  = pick(raddr1, rf_rdata1);
        rkd_value = pick(raddr2, rf_rdata2);
        stall     = load_hit(es_fwd) || load_hit(ms_fwd);
    end

endmodule

//--- design/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
    input  isa_pkg::br_kind_e br_kind,
    input  isa_pkg::word_t    pc,
    input  isa_pkg::word_t    br_offs,
    input  isa_pkg::word_t    rj_value,
    input  isa_pkg::word_t    rkd_value,
    input  logic              valid,
    input  logic              stall,
    output pipe_pkg::br_req_t br_req
);

    logic eq;
    logic ge_s;
    logic ge_u;
    logic cond;

    assign eq   = rj_value == rkd_value;
    assign ge_s = $signed(rj_value) >= $signed(rkd_value);
    assign ge_u = rj_value >= rkd_value;

    always_comb begin
        case (br_kind)
            isa_pkg::BR_B,
            isa_pkg::BR_BL,
            isa_pkg::BR_JIRL: cond = 1'b1;
            isa_pkg::BR_BEQ:  cond = eq;
            isa_pkg::BR_BNE:  cond = !eq;
            isa_pkg::BR_BLT:  cond = !ge_s;
            isa_pkg::BR_BGE:  cond = ge_s;
            isa_pkg::BR_BLTU: cond = !ge_u;
            isa_pkg::BR_BGEU: cond = ge_u;
            default:          cond = 1'b0;
        endcase
    end

    // jirl is register relative, everything else pc relative
    assign br_req = '{
        stall:  valid && stall && br_kind != isa_pkg::BR_NONE,
        taken:  valid && !stall && cond,
        target: ((br_kind == isa_pkg::BR_JIRL) ? rj_value : pc) + br_offs
    };

endmodule

//--- design/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                clk,
    input  logic                resetn,
    input  logic                fs_to_ds_valid,
    input  pipe_pkg::fs_to_ds_t fs_to_ds_bus,
    input  logic                es_allowin,
    input  pipe_pkg::fwd_t      es_fwd,
    input  pipe_pkg::fwd_t      ms_fwd,
    input  pipe_pkg::rf_write_t ws_write,
    output logic                ds_allowin,
    output logic                ds_to_es_valid,
    output pipe_pkg::ds_to_es_t ds_to_es_bus,
    output pipe_pkg::br_req_t   br_req
);

    logic                ds_valid;
    pipe_pkg::fs_to_ds_t ds_reg;
    pipe_pkg::dec_ctrl_t ctrl;
    isa_pkg::word_t      rf_rdata1;
    isa_pkg::word_t      rf_rdata2;
    isa_pkg::word_t      rj_value;
    isa_pkg::word_t      rkd_value;
    logic                ds_stall;

    assign ds_allowin     = !ds_valid || (!ds_stall && es_allowin);
    assign ds_to_es_valid = ds_valid && !ds_stall;

    // a taken branch kills whatever fetch offers this cycle
    always_ff @(posedge clk) begin
        if (!resetn || br_req.taken) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_reg <= fs_to_ds_bus;
        end
    end

    inst_decoder dec_i (
        .inst (ds_reg.inst),
        .ctrl (ctrl)
    );

    regfile rf_i (
        .clk    (clk),
        .raddr1 (ctrl.raddr1),
        .raddr2 (ctrl.raddr2),
        .write  (ws_write),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    operand_bypass byp_i (
        .raddr1    (ctrl.raddr1),
        .raddr2    (ctrl.raddr2),
        .need_r1   (ctrl.need_r1),
        .need_r2   (ctrl.need_r2),
        .rf_rdata1 (rf_rdata1),
        .rf_rdata2 (rf_rdata2),
        .es_fwd    (es_fwd),
        .ms_fwd    (ms_fwd),
        .ws_write  (ws_write),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .stall     (ds_stall)
    );

    branch_unit br_i (
        .br_kind   (ctrl.br_kind),
        .pc        (ds_reg.pc),
        .br_offs   (ctrl.br_offs),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .valid     (ds_valid),
        .stall     (ds_stall),
        .br_req    (br_req)
    );

    assign ds_to_es_bus = '{
        alu_op:       ctrl.alu_op,
        alu_src1:     ctrl.src1_is_pc ? ds_reg.pc : rj_value,
        alu_src2:     ctrl.src2_is_imm ? ctrl.imm : rkd_value,
        res_from_mem: ctrl.res_from_mem,
        mem_we:       ctrl.mem_we && ds_valid,
        rf_we:        ctrl.rf_we && ds_valid,
        rf_waddr:     ctrl.dest,
        rkd_value:    rkd_value,
        pc:           ds_reg.pc
    };

endmodule

//--- dv/decode_stage_tb.sv
`timescale 1ns/1ps

module decode_stage_tb;

    localparam int NUM_TESTS = 80;
    localparam time CLK_PERIOD = 100ns;

    // opcode fields used to build instructions
    localparam logic [5:0] ENC_OP6_ALU = 6'h00;
    localparam logic [5:0] ENC_OP6_MEM = 6'h0a;
    localparam logic [4:0] RR_OP5 [11] = '{5'h00, 5'h02, 5'h04, 5'h05, 5'h08, 5'h09,
                                           5'h0a, 5'h0b, 5'h0e, 5'h0f, 5'h10};
    localparam int         RR_BIT [11] = '{0, 1, 2, 3, 5, 4, 6, 7, 8, 9, 10};
    localparam logic [4:0] SH_OP5 [3]  = '{5'h01, 5'h09, 5'h11};
    localparam int         SH_BIT [3]  = '{8, 9, 10};
    localparam logic [3:0] I12_OP4 [6] = '{4'ha, 4'h8, 4'h9, 4'hd, 4'he, 4'hf};
    localparam int         I12_BIT [6] = '{0, 2, 3, 4, 6, 7};
    localparam logic [5:0] CB_OP6 [6]  = '{6'h16, 6'h17, 6'h18, 6'h19, 6'h1a, 6'h1b};

    logic                clk;
    logic                resetn;
    logic                fs_to_ds_valid;
    pipe_pkg::fs_to_ds_t fs_to_ds_bus;
    logic                es_allowin;
    pipe_pkg::fwd_t      es_fwd;
    pipe_pkg::fwd_t      ms_fwd;
    pipe_pkg::rf_write_t ws_write;
    logic                ds_allowin;
    logic                ds_to_es_valid;
    pipe_pkg::ds_to_es_t ds_to_es_bus;
    pipe_pkg::br_req_t   br_req;

    logic [31:0] lfsr = 32'h1103_66ee;
    logic [31:0] rf_model [32];

    decode_stage dut_i (
        .clk            (clk),
        .resetn         (resetn),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus),
        .es_allowin     (es_allowin),
        .es_fwd         (es_fwd),
        .ms_fwd         (ms_fwd),
        .ws_write       (ws_write),
        .ds_allowin     (ds_allowin),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus),
        .br_req         (br_req)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(NUM_TESTS * 20 * CLK_PERIOD);
        $display("timeout: the tests did not finish in the expected time");
        stop_with_failure();
    end

    task automatic stop_with_failure();
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic expect_true(input logic ok, input string what);
        assert (ok === 1'b1) else begin
            $display("CHECK FAILED at %0t: %s", $time, what);
            stop_with_failure();
        end
    endtask

    // taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] s);
        return {{20{s[11]}}, s};
    endfunction

    task automatic tick();
        @(posedge clk);
        #10;
    endtask

    task automatic idle_inputs();
        fs_to_ds_valid = 1'b0;
        es_fwd         = '0;
        ms_fwd         = '0;
        ws_write       = '0;
    endtask

    task automatic write_reg(input logic [4:0] a, input logic [31:0] v);
        ws_write = '{we: 1'b1, waddr: a, wdata: v};
        tick();
        ws_write = '0;
        if (a != 0) begin
            rf_model[a] = v;
        end
    endtask

    // one idle cycle to drain decode, then a transfer
    task automatic send_inst(input logic [31:0] inst, input logic [31:0] pc);
        idle_inputs();
        es_allowin = 1'b1;
        tick();
        fs_to_ds_valid = 1'b1;
        fs_to_ds_bus   = '{inst: inst, pc: pc};
        tick();
        fs_to_ds_valid = 1'b0;
        #5;
    endtask

    task automatic check_alu(input int op_bit, input logic [31:0] src1, input bit chk1,
                             input logic [31:0] src2, input logic we, input logic [4:0] wa,
                             input logic rfm, input logic mwe, input string what);
        expect_true(ds_to_es_valid, {what, ": output not valid"});
        expect_true(ds_to_es_bus.alu_op == (12'b1 << op_bit), {what, ": alu_op"});
        if (chk1) begin
            expect_true(ds_to_es_bus.alu_src1 == src1, {what, ": alu_src1"});
        end
        expect_true(ds_to_es_bus.alu_src2 == src2, {what, ": alu_src2"});
        expect_true(ds_to_es_bus.rf_we == we, {what, ": rf_we"});
        if (we) begin
            expect_true(ds_to_es_bus.rf_waddr == wa, {what, ": rf_waddr"});
        end
        expect_true(ds_to_es_bus.res_from_mem == rfm, {what, ": res_from_mem"});
        expect_true(ds_to_es_bus.mem_we == mwe, {what, ": mem_we"});
        expect_true(ds_to_es_bus.pc == fs_to_ds_bus.pc, {what, ": pc"});
    endtask

    task automatic run_alu_tests();
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [4:0]  rd;
        logic [11:0] i12;
        logic [19:0] i20;
        logic [31:0] pc;
        logic [31:0] imm;
        rj  = rand_bits(5);
        rk  = rand_bits(5);
        rd  = rand_bits(5);
        i12 = rand_bits(12);
        i20 = rand_bits(20);
        pc  = rand_bits(30) << 2;
        for (int i = 0; i < 11; i++) begin
            send_inst({ENC_OP6_ALU, 4'h0, 2'h1, RR_OP5[i], rk, rj, rd}, pc);
            check_alu(RR_BIT[i], rf_model[rj], 1, rf_model[rk], 1, rd, 0, 0, "3r op");
        end
        for (int i = 0; i < 3; i++) begin
            send_inst({ENC_OP6_ALU, 4'h1, 2'h0, SH_OP5[i], rk, rj, rd}, pc);
            check_alu(SH_BIT[i], rf_model[rj], 1, {27'b0, rk}, 1, rd, 0, 0, "shift imm");
        end
        for (int i = 0; i < 6; i++) begin
            send_inst({ENC_OP6_ALU, I12_OP4[i], i12, rj, rd}, pc);
            // the logic immediates are zero extended
            imm = (i < 3) ? sext12(i12) : {20'b0, i12};
            check_alu(I12_BIT[i], rf_model[rj], 1, imm, 1, rd, 0, 0, "imm12 op");
        end
        send_inst({6'h05, 1'b0, i20, rd}, pc);
        check_alu(11, '0, 0, {i20, 12'b0}, 1, rd, 0, 0, "lu12i.w");
        send_inst({6'h07, 1'b0, i20, rd}, pc);
        check_alu(0, pc, 1, {i20, 12'b0}, 1, rd, 0, 0, "pcaddu12i");
        send_inst({ENC_OP6_MEM, 4'h2, i12, rj, rd}, pc);
        check_alu(0, rf_model[rj], 1, sext12(i12), 1, rd, 1, 0, "ld.w");
        send_inst({ENC_OP6_MEM, 4'h6, i12, rj, rd}, pc);
        check_alu(0, rf_model[rj], 1, sext12(i12), 0, rd, 0, 1, "st.w");
        expect_true(ds_to_es_bus.rkd_value == rf_model[rd], "st.w store data");
        send_inst(32'hffff_ffff, pc);
        expect_true(ds_to_es_bus.rf_we == 1'b0 && ds_to_es_bus.alu_op == '0, "unknown inst");
    endtask

    task automatic run_forward_tests();
        logic [4:0] a;
        a = rand_bits(5) | 5'd1;
        send_inst({ENC_OP6_ALU, 4'h0, 2'h1, 5'h00, a, a, 5'd3}, 32'h100);
        es_allowin = 1'b0;
        es_fwd   = '{res_from_mem: 1'b0, rf_we: 1'b1, rf_waddr: a, wdata: 32'h1111_0001};
        ms_fwd   = '{res_from_mem: 1'b0, rf_we: 1'b1, rf_waddr: a, wdata: 32'h2222_0002};
        ws_write = '{we: 1'b1, waddr: a, wdata: 32'h3333_0003};
        #5;
        expect_true(ds_to_es_bus.alu_src1 == 32'h1111_0001, "execute forward priority");
        es_fwd.rf_we = 1'b0;
        #5;
        expect_true(ds_to_es_bus.alu_src1 == 32'h2222_0002, "memory forward priority");
        ms_fwd.rf_we = 1'b0;
        #5;
        expect_true(ds_to_es_bus.alu_src2 == 32'h3333_0003, "writeback forward");
        ws_write.we = 1'b0;
        send_inst({ENC_OP6_ALU, 4'h0, 2'h1, 5'h00, 5'd0, 5'd0, 5'd3}, 32'h104);
        es_fwd = '{res_from_mem: 1'b0, rf_we: 1'b1, rf_waddr: 5'd0, wdata: 32'hdead_beef};
        #5;
        expect_true(ds_to_es_bus.alu_src1 == '0, "r0 not zero");
        // load-use on the same source
        send_inst({ENC_OP6_ALU, 4'h0, 2'h1, 5'h00, 5'd0, a, 5'd3}, 32'h108);
        es_fwd = '{res_from_mem: 1'b1, rf_we: 1'b1, rf_waddr: a, wdata: 32'h4444_0004};
        #5;
        expect_true(!ds_to_es_valid && !ds_allowin, "load-use stall missing");
        tick();
        expect_true(!ds_to_es_valid && !ds_allowin, "load-use stall dropped early");
        es_fwd.res_from_mem = 1'b0;
        #5;
        expect_true(ds_to_es_valid, "stall did not release");
        expect_true(ds_to_es_bus.alu_src1 == 32'h4444_0004, "value after stall");
        send_inst({CB_OP6[0], 16'h0004, a, a}, 32'h10c);
        es_fwd = '{res_from_mem: 1'b1, rf_we: 1'b1, rf_waddr: a, wdata: '0};
        #5;
        expect_true(br_req.stall && !br_req.taken, "stalled branch");
    endtask

    task automatic run_branch_test(input int kind, input int iter);
        logic [4:0]  rj;
        logic [4:0]  rd;
        logic [15:0] offs;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pc;
        logic        exp_taken;
        rj   = rand_bits(5) | 5'd1;
        rd   = (iter % 4 == 3) ? rj : (rand_bits(5) | 5'd1);
        offs = rand_bits(16);
        pc   = rand_bits(30) << 2;
        if (iter % 2 == 1 && rd != rj) begin
            write_reg(rj, rand_bits(32) | 32'h8000_0000);
            write_reg(rd, rand_bits(32) & 32'h7fff_ffff);
        end
        a = rf_model[rj];
        b = rf_model[rd];
        case (kind)
            0:       exp_taken = a == b;
            1:       exp_taken = a != b;
            2:       exp_taken = $signed(a) < $signed(b);
            3:       exp_taken = $signed(a) >= $signed(b);
            4:       exp_taken = a < b;
            default: exp_taken = a >= b;
        endcase
        send_inst({CB_OP6[kind], offs, rj, rd}, pc);
        expect_true(br_req.taken == exp_taken, "conditional branch decision");
        expect_true(!ds_to_es_bus.rf_we, "conditional branch writes a register");
        if (exp_taken) begin
            expect_true(br_req.target == pc + {{14{offs[15]}}, offs, 2'b0}, "branch target");
        end
        // offer a fetch in the branch cycle, dropped when taken
        fs_to_ds_valid = 1'b1;
        fs_to_ds_bus   = '{inst: {ENC_OP6_ALU, 4'h0, 2'h1, 5'h00, 15'h0}, pc: pc + 4};
        tick();
        fs_to_ds_valid = 1'b0;
        #5;
        expect_true(ds_to_es_valid == !exp_taken, "slot after branch");
    endtask

    task automatic run_jump_tests();
        logic [25:0] o26;
        logic [15:0] o16;
        logic [4:0]  rj;
        logic [4:0]  rd;
        logic [31:0] pc;
        o26 = rand_bits(26);
        o16 = rand_bits(16);
        rj  = rand_bits(5);
        rd  = rand_bits(5);
        pc  = rand_bits(30) << 2;
        send_inst({6'h14, o26[15:0], o26[25:16]}, pc);
        expect_true(br_req.taken && !ds_to_es_bus.rf_we, "b");
        expect_true(br_req.target == pc + {{4{o26[25]}}, o26, 2'b0}, "b target");
        send_inst({6'h15, o26[15:0], o26[25:16]}, pc);
        expect_true(br_req.taken && br_req.target == pc + {{4{o26[25]}}, o26, 2'b0}, "bl");
        check_alu(0, pc, 1, 32'd4, 1, 5'd1, 0, 0, "bl link");
        send_inst({6'h13, o16, rj, rd}, pc);
        expect_true(br_req.taken, "jirl not taken");
        expect_true(br_req.target == rf_model[rj] + {{14{o16[15]}}, o16, 2'b0}, "jirl target");
        check_alu(0, pc, 1, 32'd4, 1, rd, 0, 0, "jirl link");
    endtask

    task automatic run_backpressure_test();
        pipe_pkg::ds_to_es_t held;
        send_inst({ENC_OP6_ALU, 4'ha, 12'h123, 5'd4, 5'd5}, 32'h200);
        es_allowin = 1'b0;
        #5;
        held = ds_to_es_bus;
        // a younger fetch waits upstream
        fs_to_ds_bus = '{inst: {ENC_OP6_ALU, 4'ha, 12'h456, 5'd6, 5'd7}, pc: 32'h204};
        for (int i = 0; i < 3; i++) begin
            fs_to_ds_valid = 1'b1;
            tick();
            expect_true(!ds_allowin && ds_to_es_valid, "back-pressure flow control");
            expect_true(ds_to_es_bus == held, "held bus changed");
        end
        fs_to_ds_valid = 1'b0;
        es_allowin = 1'b1;
    endtask

    initial begin
        resetn       = 1'b0;
        es_allowin   = 1'b1;
        fs_to_ds_bus = '0;
        idle_inputs();
        rf_model[0] = '0;
        for (int i = 0; i < 5; i++) begin
            tick();
            expect_true(!ds_to_es_valid && !br_req.taken && ds_allowin, "state in reset");
        end
        resetn = 1'b1;
        tick();
        expect_true(!ds_to_es_valid && !br_req.taken && ds_allowin, "state after reset");
        for (int i = 1; i < 32; i++) begin
            write_reg(i[4:0], rand_bits(32));
        end
        run_alu_tests();
        run_alu_tests();
        run_forward_tests();
        for (int k = 0; k < 6; k++) begin
            for (int n = 0; n < 4; n++) begin
                run_branch_test(k, n);
            end
        end
        run_jump_tests();
        run_backpressure_test();
        $display("Done: no errors");
        $finish;
    end

endmodule

//--- filelist.f
design/isa_pkg.sv
design/pipe_pkg.sv
design/inst_decoder.sv
design/regfile.sv
design/operand_bypass.sv
design/branch_unit.sv
design/decode_stage.sv
dv/decode_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module decode_stage_tb \
    -f filelist.f -o decode_stage_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/decode_stage_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Done: errors found" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0
